// File: rtl/copper_pkg.sv
`default_nettype none

package copper_pkg;

    // Beam coordinate and program counter widths
    localparam int POS_W = 11;
    localparam int PC_W  = 10;

    // 640x480 mode, totals include blanking
    localparam logic [POS_W-1:0] H_TOTAL = 11'd800;
    localparam logic [POS_W-1:0] V_TOTAL = 11'd525;

    // Restart fires this many pixels before the end of the last blanking line
    localparam logic [POS_W-1:0] RESTART_H_OFS = 11'd4;

    // XR register number of the copper control register
    localparam logic [3:0] XR_COPP_CTRL = 4'h1;

    // Upper address bits of the XR memory regions a MOVE can reach
    localparam logic [15:0] XR_COLOR_BASE  = 16'h8000;
    localparam logic [15:0] XR_COPPER_BASE = 16'hC000;

    // Opcodes in insn[31:28], anything else is ignored (old MOVEF is 4'b1010)
    typedef enum logic [3:0] {
        OP_WAIT  = 4'b0000,
        OP_SKIP  = 4'b0010,
        OP_JMP   = 4'b0100,
        OP_MOVER = 4'b1001,
        OP_MOVEP = 4'b1011,
        OP_MOVEC = 4'b1100
    } copp_op_e;

    // Execution FSM
    typedef enum logic [2:0] {
        ST_INIT    = 3'd0,
        ST_WAIT    = 3'd1,
        ST_LATCH   = 3'd2,
        ST_PRECOMP = 3'd3,
        ST_EXEC    = 3'd4
    } copp_state_e;

    // Program counter update requested by the FSM
    typedef enum logic [1:0] {
        PC_HOLD      = 2'd0,
        PC_LOAD_INIT = 2'd1,
        PC_INC       = 2'd2,
        PC_LOAD_JMP  = 2'd3
    } pc_cmd_e;

    // One copper instruction word
    // arg holds address or V position, lo holds data or H position and flags
    typedef struct packed {
        copp_op_e    opcode;
        logic [11:0] arg;
        logic [15:0] lo;
    } copp_insn_t;

    typedef struct packed {
        logic [POS_W-1:0] h;
        logic [POS_W-1:0] v;
    } beam_pos_t;

    // Host write to an internal config register
    typedef struct packed {
        logic        wr;
        logic [3:0]  num;
        logic [15:0] data;
    } copp_reg_wr_t;

    // Write into XR register or memory space
    typedef struct packed {
        logic        en;
        logic [15:0] addr;
        logic [15:0] data;
    } xr_wr_t;

    // Targets currently taken by a host access
    typedef struct packed {
        logic xr_reg;
        logic color_mem;
        logic copper_mem;
    } xr_busy_t;

endpackage

`default_nettype wire

// File: rtl/copper_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module copper_ctrl (
    input  wire logic                       clk,
    input  wire logic                       copp_reset,
    input  wire copper_pkg::copp_reg_wr_t   reg_wr_i,
    input  wire copper_pkg::beam_pos_t      beam_i,
    input  wire copper_pkg::copp_op_e       opcode_i,
    input  wire logic                       pos_reached_i,
    input  wire logic                       move_stall_i,
    output logic [copper_pkg::PC_W-1:0]     init_pc_o,
    output copper_pkg::pc_cmd_e             pc_cmd_o,
    output logic                            latch_o,
    output logic                            cmp_o,
    output logic                            fire_o,
    output logic                            mem_rd_en_o
);

    logic                        en_q;
    logic                        frame_restart;
    copper_pkg::copp_state_e     state_q;
    copper_pkg::copp_state_e     state_d;

    // Control register layout
    // [15] enable, [PC_W-1:0] initial PC, remaining bits unused
    always_ff @(posedge clk) begin
        if (copp_reset) begin
            en_q      <= 1'b0;
            init_pc_o <= '0;
        end else if (reg_wr_i.wr && reg_wr_i.num == copper_pkg::XR_COPP_CTRL) begin
            en_q      <= reg_wr_i.data[15];
            init_pc_o <= reg_wr_i.data[copper_pkg::PC_W-1:0];
        end
    end

    // Restart point near the end of vertical blanking
    // Lets the first instruction compare on the first visible pixel
    assign frame_restart =
        (beam_i.h == copper_pkg::H_TOTAL - copper_pkg::RESTART_H_OFS) &&
        (beam_i.v == copper_pkg::V_TOTAL - 1'b1);

    always_comb begin
        state_d  = state_q;
        pc_cmd_o = copper_pkg::PC_HOLD;
        latch_o  = 1'b0;
        cmp_o    = 1'b0;
        fire_o   = 1'b0;

        if (frame_restart) begin
            // Restart wins over whatever is in progress
            state_d  = copper_pkg::ST_INIT;
            pc_cmd_o = copper_pkg::PC_LOAD_INIT;
        end else begin
            case (state_q)
                // Idle until enabled, then start the first fetch
                copper_pkg::ST_INIT: begin
                    if (en_q) begin
                        state_d = copper_pkg::ST_WAIT;
                    end
                end
                // Read in flight from the current PC
                copper_pkg::ST_WAIT: begin
                    if (en_q) begin
                        // Step PC now, the read already has the old address
                        state_d  = copper_pkg::ST_LATCH;
                        pc_cmd_o = copper_pkg::PC_INC;
                    end else begin
                        state_d = copper_pkg::ST_INIT;
                    end
                end
                // Memory word is valid this cycle
                copper_pkg::ST_LATCH: begin
                    latch_o = 1'b1;
                    state_d = copper_pkg::ST_PRECOMP;
                end
                // Beam comparison registered for use in EXEC
                copper_pkg::ST_PRECOMP: begin
                    cmp_o   = 1'b1;
                    state_d = copper_pkg::ST_EXEC;
                end
                copper_pkg::ST_EXEC: begin
                    case (opcode_i)
                        copper_pkg::OP_WAIT: begin
                            // Not there yet, so go round PRECOMP and check again
                            if (pos_reached_i) begin
                                state_d = copper_pkg::ST_WAIT;
                            end else begin
                                state_d = copper_pkg::ST_PRECOMP;
                            end
                        end
                        copper_pkg::OP_SKIP: begin
                            // PC already points past SKIP, one more step skips the next
                            if (pos_reached_i) begin
                                pc_cmd_o = copper_pkg::PC_INC;
                            end
                            state_d = copper_pkg::ST_WAIT;
                        end
                        copper_pkg::OP_JMP: begin
                            pc_cmd_o = copper_pkg::PC_LOAD_JMP;
                            state_d  = copper_pkg::ST_WAIT;
                        end
                        copper_pkg::OP_MOVER,
                        copper_pkg::OP_MOVEP,
                        copper_pkg::OP_MOVEC: begin
                            // Hold in EXEC while the host owns the target
                            if (!move_stall_i) begin
                                fire_o  = 1'b1;
                                state_d = copper_pkg::ST_WAIT;
                            end
                        end
                        default: begin
                            // Unknown opcode acts as a four-cycle NOP
                            state_d = copper_pkg::ST_WAIT;
                        end
                    endcase
                end
                default: begin
                    state_d = copper_pkg::ST_INIT;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (copp_reset) begin
            state_q     <= copper_pkg::ST_INIT;
            mem_rd_en_o <= 1'b0;
        end else begin
            state_q     <= state_d;
            // Read strobe covers exactly the cycle spent in ST_WAIT
            mem_rd_en_o <= (state_d == copper_pkg::ST_WAIT);
        end
    end

    // Every read is taken by LATCH next cycle unless the FSM dropped back to idle
    a_rd_then_latch: assert property (@(posedge clk) disable iff (copp_reset)
        mem_rd_en_o |=> state_q == copper_pkg::ST_LATCH || state_q == copper_pkg::ST_INIT);

    // A MOVE never fires into a busy target
    a_no_fire_busy: assert property (@(posedge clk) disable iff (copp_reset)
        fire_o |-> !move_stall_i && state_q == copper_pkg::ST_EXEC);

endmodule

`default_nettype wire

// File: rtl/copper_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module copper_fetch (
    input  wire logic                       clk,
    input  wire logic                       copp_reset,
    input  wire copper_pkg::pc_cmd_e        pc_cmd_i,
    input  wire logic [copper_pkg::PC_W-1:0] init_pc_i,
    input  wire logic                       latch_i,
    input  wire copper_pkg::copp_insn_t     mem_data_i,
    output logic [copper_pkg::PC_W-1:0]     mem_addr_o,
    output copper_pkg::copp_insn_t          insn_o
);

    logic [copper_pkg::PC_W-1:0] pc_q;

    // Program counter
    always_ff @(posedge clk) begin
        if (copp_reset) begin
            pc_q <= '0;
        end else begin
            case (pc_cmd_i)
                copper_pkg::PC_LOAD_INIT: pc_q <= init_pc_i;
                copper_pkg::PC_INC:       pc_q <= pc_q + 1'b1;
                // Jump target lives in insn[26:17]
                copper_pkg::PC_LOAD_JMP:  pc_q <= insn_o.arg[copper_pkg::PC_W:1];
                default:                  pc_q <= pc_q;
            endcase
        end
    end

    // Read address always follows the PC
    assign mem_addr_o = pc_q;

    // Current instruction, taken one cycle after the read
    always_ff @(posedge clk) begin
        if (latch_i) begin
            insn_o <= mem_data_i;
        end
    end

endmodule

`default_nettype wire

// File: rtl/copper_beam_cmp.sv
`timescale 1ns/1ps
`default_nettype none

module copper_beam_cmp (
    input  wire logic                   clk,
    input  wire logic                   copp_reset,
    input  wire logic                   cmp_i,
    input  wire copper_pkg::beam_pos_t  beam_i,
    input  wire copper_pkg::copp_insn_t insn_i,
    output logic                        pos_reached_o
);

    logic v_ge_q;
    logic h_ge_q;
    logic ignore_v;
    logic ignore_h;
    logic wait_forever;

    // V position sits in insn[26:16], H position in insn[14:4]
    always_ff @(posedge clk) begin
        if (copp_reset) begin
            v_ge_q <= 1'b0;
            h_ge_q <= 1'b0;
        end else if (cmp_i) begin
            v_ge_q <= beam_i.v >= insn_i.arg[copper_pkg::POS_W-1:0];
            h_ge_q <= beam_i.h >= insn_i.lo[copper_pkg::POS_W+3:4];
        end
    end

    // Flag bits [0] ignore V, [1] ignore H
    assign ignore_v = insn_i.lo[0];
    assign ignore_h = insn_i.lo[1];

    // WAIT ignoring both axes means wait for end of frame
    assign wait_forever = (insn_i.opcode == copper_pkg::OP_WAIT) && ignore_v && ignore_h;

    // Ignored axis counts as reached, so SKIP with both flags always skips
    assign pos_reached_o = !wait_forever &&
                           (ignore_v || v_ge_q) &&
                           (ignore_h || h_ge_q);

endmodule

`default_nettype wire

// File: rtl/copper_move.sv
`timescale 1ns/1ps
`default_nettype none

module copper_move (
    input  wire logic                   clk,
    input  wire logic                   copp_reset,
    input  wire logic                   fire_i,
    input  wire copper_pkg::copp_insn_t insn_i,
    input  wire copper_pkg::xr_busy_t   busy_i,
    output logic                        move_stall_o,
    output copper_pkg::xr_wr_t          xr_wr_o
);

    logic        target_busy;
    logic [15:0] addr_d;
    logic        wr_en_q;
    logic [15:0] wr_addr_q;
    logic [15:0] wr_data_q;

    // Target decode and full XR address
    always_comb begin
        target_busy = 1'b0;
        addr_d      = '0;
        case (insn_i.opcode)
            // XR register number in insn[23:16]
            copper_pkg::OP_MOVER: begin
                target_busy = busy_i.xr_reg;
                addr_d      = {8'h00, insn_i.arg[7:0]};
            end
            // Palette entry in insn[23:16]
            copper_pkg::OP_MOVEP: begin
                target_busy = busy_i.color_mem;
                addr_d      = copper_pkg::XR_COLOR_BASE + {8'h00, insn_i.arg[7:0]};
            end
            // Copper memory word in insn[26:16]
            copper_pkg::OP_MOVEC: begin
                target_busy = busy_i.copper_mem;
                addr_d      = copper_pkg::XR_COPPER_BASE + {5'b00000, insn_i.arg[10:0]};
            end
            default: begin
                target_busy = 1'b0;
            end
        endcase
    end

    // Only MOVE opcodes can see a busy target
    assign move_stall_o = target_busy;

    // Single-cycle write strobe
    always_ff @(posedge clk) begin
        if (copp_reset) begin
            wr_en_q <= 1'b0;
        end else begin
            wr_en_q <= fire_i;
        end
    end

    always_ff @(posedge clk) begin
        if (fire_i) begin
            wr_addr_q <= addr_d;
            wr_data_q <= insn_i.lo;
        end
    end

    assign xr_wr_o = '{en: wr_en_q, addr: wr_addr_q, data: wr_data_q};

    // Writes are at least one instruction apart
    a_wr_single: assert property (@(posedge clk) disable iff (copp_reset)
        wr_en_q |=> !wr_en_q);

endmodule

`default_nettype wire

// File: rtl/copper_top.sv
`timescale 1ns/1ps
`default_nettype none

module copper_top (
    input  wire logic                       clk,
    input  wire logic                       copp_reset,
    input  wire copper_pkg::copp_reg_wr_t   reg_wr_i,
    input  wire copper_pkg::beam_pos_t      beam_i,
    input  wire copper_pkg::xr_busy_t       busy_i,
    input  wire copper_pkg::copp_insn_t     mem_data_i,
    output logic [copper_pkg::PC_W-1:0]     mem_addr_o,
    output logic                            mem_rd_en_o,
    output copper_pkg::xr_wr_t              xr_wr_o
);

    // FSM to datapath
    logic [copper_pkg::PC_W-1:0] init_pc;
    copper_pkg::pc_cmd_e         pc_cmd;
    logic                        latch;
    logic                        cmp;
    logic                        fire;

    // Datapath back to FSM
    copper_pkg::copp_insn_t      insn;
    logic                        pos_reached;
    logic                        move_stall;

    copper_ctrl u_ctrl (
        .clk           (clk),
        .copp_reset    (copp_reset),
        .reg_wr_i      (reg_wr_i),
        .beam_i        (beam_i),
        .opcode_i      (insn.opcode),
        .pos_reached_i (pos_reached),
        .move_stall_i  (move_stall),
        .init_pc_o     (init_pc),
        .pc_cmd_o      (pc_cmd),
        .latch_o       (latch),
        .cmp_o         (cmp),
        .fire_o        (fire),
        .mem_rd_en_o   (mem_rd_en_o)
    );

    copper_fetch u_fetch (
        .clk        (clk),
        .copp_reset (copp_reset),
        .pc_cmd_i   (pc_cmd),
        .init_pc_i  (init_pc),
        .latch_i    (latch),
        .mem_data_i (mem_data_i),
        .mem_addr_o (mem_addr_o),
        .insn_o     (insn)
    );

    copper_beam_cmp u_beam_cmp (
        .clk           (clk),
        .copp_reset    (copp_reset),
        .cmp_i         (cmp),
        .beam_i        (beam_i),
        .insn_i        (insn),
        .pos_reached_o (pos_reached)
    );

    copper_move u_move (
        .clk          (clk),
        .copp_reset   (copp_reset),
        .fire_i       (fire),
        .insn_i       (insn),
        .busy_i       (busy_i),
        .move_stall_o (move_stall),
        .xr_wr_o      (xr_wr_o)
    );

endmodule

`default_nettype wire

// File: bench/copper_tb_tests.svh
    // Disabled copper issues no read and no write across a frame restart
    task automatic test_idle();
        restart_frame(11'd0);
        repeat (30) begin
            @(negedge clk);
            check_bit("idle rd_en", 1'b0, mem_rd_en_o);
            check_bit("idle wr_en", 1'b0, xr_wr_o.en);
        end
    endtask

    // Random MOVEs from PC 100, writes in program order four cycles apart
    task automatic test_moves();
        copper_pkg::xr_wr_t   exp_q[$];
        copper_pkg::copp_op_e op;
        logic [31:0]          r;
        for (int i = 0; i < 6; i++) begin
            r = $random(seed);
            case (r % 3)
                0:       op = copper_pkg::OP_MOVER;
                1:       op = copper_pkg::OP_MOVEP;
                default: op = copper_pkg::OP_MOVEC;
            endcase
            mem[10'(100 + i)] = {op, r[27:16], r[15:0]};
            exp_q.push_back(exp_wr(op, r[27:16], r[15:0]));
        end
        // Both ignore flags, parks until the next restart
        mem[106] = {copper_pkg::OP_WAIT, 12'd0, 16'h0003};
        set_ctrl(1'b1, 10'd100);
        restart_frame(11'd0);
        wait_write("move 0", exp_q[0]);
        for (int i = 1; i < 6; i++) begin
            no_write("move gap", 3);
            @(negedge clk);
            check_wr($sformatf("move %0d", i), exp_q[i], xr_wr_o);
        end
        no_write("move tail", 20);
    endtask

    // WAIT on line 100, then a both-flags WAIT that only a restart ends
    task automatic test_wait();
        // V in arg, lo[1] ignores H
        mem[200] = {copper_pkg::OP_WAIT, 12'd100, 16'h0002};
        mem[201] = {copper_pkg::OP_MOVER, 12'h012, 16'hA5A5};
        mem[202] = {copper_pkg::OP_WAIT, 12'd0, 16'h0003};
        mem[203] = {copper_pkg::OP_MOVER, 12'h013, 16'h5A5A};
        set_ctrl(1'b1, 10'd200);
        restart_frame(11'd40);
        no_write("wait below v", 60);
        beam_i.v = 11'd99;
        no_write("wait one line early", 20);
        beam_i.v = 11'd100;
        wait_write("wait reached", exp_wr(copper_pkg::OP_MOVER, 12'h012, 16'hA5A5));
        // Late in the frame but short of the restart point
        beam_i = '{h: 11'd700, v: 11'd520};
        no_write("wait forever", 80);
        restart_frame(11'd200);
        wait_write("wait after restart", exp_wr(copper_pkg::OP_MOVER, 12'h012, 16'hA5A5));
        no_write("wait held again", 20);
    endtask

    // SKIP taken, SKIP not taken, then JMP over a MOVE
    task automatic test_skip_jmp();
        mem[300] = {copper_pkg::OP_SKIP, 12'd0, 16'h0002};
        mem[301] = {copper_pkg::OP_MOVER, 12'h020, 16'h1111};
        mem[302] = {copper_pkg::OP_MOVER, 12'h021, 16'h2222};
        mem[303] = {copper_pkg::OP_SKIP, 12'd500, 16'h0002};
        mem[304] = {copper_pkg::OP_MOVER, 12'h022, 16'h3333};
        // Jump target in insn[26:17]
        mem[305] = {copper_pkg::OP_JMP, 1'b0, 10'd310, 1'b0, 16'h0000};
        mem[306] = {copper_pkg::OP_MOVER, 12'h023, 16'h4444};
        mem[310] = {copper_pkg::OP_MOVEP, 12'h024, 16'h5555};
        mem[311] = {copper_pkg::OP_WAIT, 12'd0, 16'h0003};
        set_ctrl(1'b1, 10'd300);
        restart_frame(11'd10);
        wait_write("skip taken", exp_wr(copper_pkg::OP_MOVER, 12'h021, 16'h2222));
        wait_write("skip not taken", exp_wr(copper_pkg::OP_MOVER, 12'h022, 16'h3333));
        wait_write("jmp target", exp_wr(copper_pkg::OP_MOVEP, 12'h024, 16'h5555));
        no_write("jmp tail", 30);
    endtask

    // MOVEP held off by a busy colour memory, one write once it frees up
    task automatic test_busy();
        busy_i.color_mem = 1'b1;
        mem[400] = {copper_pkg::OP_MOVEP, 12'h0C0, 16'hBEEF};
        mem[401] = {copper_pkg::OP_WAIT, 12'd0, 16'h0003};
        set_ctrl(1'b1, 10'd400);
        restart_frame(11'd0);
        no_write("busy stall", 40);
        busy_i.color_mem = 1'b0;
        wait_write("busy release", exp_wr(copper_pkg::OP_MOVEP, 12'h0C0, 16'hBEEF));
        no_write("busy single", 20);
    endtask

    // Unknown opcodes fall through as NOPs
    task automatic test_illegal();
        // Old MOVEF encoding first
        mem[500] = 32'hA000_1234;
        mem[501] = 32'h1FFF_FFFF;
        mem[502] = 32'hE000_0000;
        mem[503] = {copper_pkg::OP_MOVEC, 12'h7FF, 16'hC0DE};
        mem[504] = {copper_pkg::OP_WAIT, 12'd0, 16'h0003};
        set_ctrl(1'b1, 10'd500);
        restart_frame(11'd0);
        wait_write("illegal skipped", exp_wr(copper_pkg::OP_MOVEC, 12'h7FF, 16'hC0DE));
        no_write("illegal tail", 20);
    endtask

// File: bench/copper_tb.sv
`timescale 1ns/1ps
`default_nettype none

module copper_tb;

    localparam int CLK_NS       = 4;
    localparam int RESET_CYCLES = 16;
    localparam int WR_TIMEOUT   = 40;
    // Cycle budget of each test in run order
    localparam int TEST_CYCLES  = 40 + 60 + 220 + 60 + 90 + 50;

    logic                        clk = 1'b0;
    logic                        copp_reset;
    copper_pkg::copp_reg_wr_t    reg_wr_i;
    copper_pkg::beam_pos_t       beam_i;
    copper_pkg::xr_busy_t        busy_i;
    copper_pkg::copp_insn_t      mem_data_i = '0;
    logic [copper_pkg::PC_W-1:0] mem_addr_o;
    logic                        mem_rd_en_o;
    copper_pkg::xr_wr_t          xr_wr_o;

    // Copper memory image and the read seen on the last falling edge
    copper_pkg::copp_insn_t      mem [1024];
    logic                        rd_pend = 1'b0;
    logic [copper_pkg::PC_W-1:0] rd_addr = '0;
    integer                      seed;

    copper_top u_dut (.*);

    always #(CLK_NS / 2) clk = ~clk;

    // Word comes back on the falling edge one cycle after the read
    always @(negedge clk) begin
        if (rd_pend) begin
            mem_data_i <= mem[rd_addr];
        end
        rd_pend <= mem_rd_en_o;
        rd_addr <= mem_addr_o;
    end

    // Watchdog, twice the summed test budgets
    initial begin
        #((RESET_CYCLES + 2 * TEST_CYCLES) * CLK_NS);
        report_fail("Watchdog expired before the test sequence finished");
    end

    initial begin
        copp_reset = 1'b1;
        reg_wr_i   = '0;
        beam_i     = '0;
        busy_i     = '0;
        seed       = 9618;
        // Opcode F is unknown, so every unused word is a NOP tagged with its address
        for (int i = 0; i < 1024; i++) begin
            mem[10'(i)] = 32'hF000_0000 | 32'(i);
        end
        repeat (RESET_CYCLES) @(negedge clk);
        copp_reset = 1'b0;
        test_idle();
        test_moves();
        test_wait();
        test_skip_jmp();
        test_busy();
        test_illegal();
        $display("Result: PASSED");
        $finish;
    end

    task automatic report_fail(string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_wr(string name, copper_pkg::xr_wr_t exp, copper_pkg::xr_wr_t act);
        if (act !== exp) begin
            report_fail($sformatf(
                "ERR %s: expected en=%0b addr=%h data=%h, actual en=%0b addr=%h data=%h",
                name, exp.en, exp.addr, exp.data, act.en, act.addr, act.data));
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (act !== exp) begin
            report_fail($sformatf("ERR %s: expected %0b, actual %0b", name, exp, act));
        end
    endtask

    // Expected XR write, region base plus instruction address
    function automatic copper_pkg::xr_wr_t exp_wr(copper_pkg::copp_op_e op,
                                                   logic [11:0] arg, logic [15:0] data);
        copper_pkg::xr_wr_t w;
        w.en   = 1'b1;
        w.data = data;
        case (op)
            copper_pkg::OP_MOVEP: w.addr = copper_pkg::XR_COLOR_BASE + {8'h00, arg[7:0]};
            copper_pkg::OP_MOVEC: w.addr = copper_pkg::XR_COPPER_BASE + {5'h00, arg[10:0]};
            default:              w.addr = {8'h00, arg[7:0]};
        endcase
        return w;
    endfunction

    // Control word, enable in [15] and initial PC in the low bits
    task automatic set_ctrl(logic en, logic [copper_pkg::PC_W-1:0] pc);
        reg_wr_i = '{wr: 1'b1, num: copper_pkg::XR_COPP_CTRL, data: {en, 5'b00000, pc}};
        @(negedge clk);
        reg_wr_i = '0;
    endtask

    // One cycle at the restart point, then the beam moves to line v_next
    task automatic restart_frame(logic [10:0] v_next);
        beam_i.h = copper_pkg::H_TOTAL - copper_pkg::RESTART_H_OFS;
        beam_i.v = copper_pkg::V_TOTAL - 11'd1;
        @(negedge clk);
        beam_i = '{h: 11'd0, v: v_next};
    endtask

    task automatic wait_write(string name, copper_pkg::xr_wr_t exp);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!xr_wr_o.en && n < WR_TIMEOUT);
        if (!xr_wr_o.en) begin
            report_fail($sformatf("%s: no write arrived within %0d cycles", name, WR_TIMEOUT));
        end else begin
            check_wr(name, exp, xr_wr_o);
        end
    endtask

    task automatic no_write(string name, int n);
        repeat (n) begin
            @(negedge clk);
            check_bit(name, 1'b0, xr_wr_o.en);
        end
    endtask

    `include "copper_tb_tests.svh"

endmodule

`default_nettype wire

// File: src.f
+incdir+bench
rtl/copper_pkg.sv
rtl/copper_ctrl.sv
rtl/copper_fetch.sv
rtl/copper_beam_cmp.sv
rtl/copper_move.sv
rtl/copper_top.sv
bench/copper_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --assert --top-module copper_tb -f src.f -o copper_sim
	./obj_dir/copper_sim | tee /dev/stderr | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir
